// File: common/tx_pkg.sv
package tx_pkg;

    // Datapath widths
    localparam int WORD_W       = 16;
    localparam int NIB_W        = 4;
    localparam int NIB_PER_WORD = WORD_W / NIB_W;
    localparam int NIB_IDX_W    = $clog2(NIB_PER_WORD);
    localparam int PHASE_W      = $clog2(WORD_W);  // One phase per serial bit

    // Input buffer, depth equals the credits upstream starts with
    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W   = $clog2(FIFO_DEPTH + 1);

    // Cycles from word_load to the first bit of that word on dout
    // 1 word reg, 3 wait for nib_load, 1 shift reg, 1 output reg
    localparam int SOF_DELAY = 6;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [NIB_W-1:0]    nibble_t;
    typedef logic [PHASE_W-1:0]  phase_t;
    typedef logic [CREDIT_W-1:0] credit_t;

    localparam word_t IDLE_WORD = 16'hAAAA;  // Alternating bits keep the line toggling

    typedef enum logic {
        DRV_OFF = 1'b0,  // Pair parked at rest level
        DRV_ON  = 1'b1
    } drv_state_e;

endpackage

// File: src/tx_word_fifo.sv
`default_nettype none

module tx_word_fifo import tx_pkg::*; (
    input  wire logic  clk_tx,
    input  wire logic  arst_n,
    input  wire word_t din,
    input  wire logic  din_valid,      // Only sent while upstream holds a credit
    input  wire logic  pop,            // Word strobe, FIFO decides if it pops
    output word_t      head,
    output logic       head_valid,
    output logic       credit_return   // One pulse per word popped
);

    word_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    credit_t           count;          // Occupancy 0..FIFO_DEPTH
    logic              do_pop;

    // Credits guarantee a free slot, no full check needed
    always_ff @(posedge clk_tx) begin
        if (din_valid) begin
            mem[wr_ptr] <= din;
        end
    end

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];  // First-word fall-through
    assign do_pop     = pop && head_valid;  // Empty slot goes out as idle instead

    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (din_valid) begin
                wr_ptr <= wr_ptr + PTR_W'(1);  // Wraps, depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
        end
    end

    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            case ({din_valid, do_pop})
                2'b10:   count <= count + CREDIT_W'(1);
                2'b01:   count <= count - CREDIT_W'(1);
                default: count <= count;  // Both or neither, level unchanged
            endcase
        end
    end

    // Credit goes back the cycle after the slot frees up
    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            credit_return <= 1'b0;
        end else begin
            credit_return <= do_pop;
        end
    end

endmodule

`default_nettype wire

// File: src/tx_phase_counter.sv
`default_nettype none

module tx_phase_counter import tx_pkg::*; (
    input  wire logic clk_tx,
    input  wire logic arst_n,
    output logic      nib_load,   // Quarter rate, every fourth bit
    output logic      word_load   // Word rate, every sixteenth bit
);

    phase_t phase;  // Bit position within the current word

    // Free running, stands in for the two divide-by-2 stages
    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            phase <= '0;
        end else begin
            phase <= phase + PHASE_W'(1);  // 15 rolls over to 0
        end
    end

    // Last bit of each nibble
    assign nib_load = &phase[NIB_IDX_W-1:0];

    // Last bit of the word, coincides with the fourth nib_load
    assign word_load = &phase;

endmodule

`default_nettype wire

// File: mux/hr_16t4_mux.sv
`default_nettype none

module hr_16t4_mux import tx_pkg::*; (
    input  wire logic  clk_tx,
    input  wire logic  arst_n,
    input  wire logic  word_load,
    input  wire logic  nib_load,
    input  wire word_t din,       // True or inverted word per lane
    output nibble_t    nib        // Nibble due at the next nib_load
);

    word_t                 din_reorder;
    word_t                 word_q;  // Nibble n held at [4n +: 4]
    logic [NIB_IDX_W-1:0]  idx;

    // MSB first, nibble n carries din bits 15-4n down to 12-4n
    always_comb begin
        for (int n = 0; n < NIB_PER_WORD; n++) begin
            din_reorder[n*NIB_W +: NIB_W] = din[WORD_W-1-n*NIB_W -: NIB_W];
        end
    end

    // Reordered word captured on the word strobe
    always_ff @(posedge clk_tx) begin
        if (word_load) begin
            word_q <= din_reorder;
        end
    end

    // word_load lands on the same edge as the last nib_load of a word
    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
        end else if (word_load) begin
            idx <= '0;                       // Restart at the top nibble
        end else if (nib_load) begin
            idx <= idx + NIB_IDX_W'(1);
        end
    end

    // At that shared edge the old word still shows its last nibble
    assign nib = word_q[idx*NIB_W +: NIB_W];

endmodule

`default_nettype wire

// File: mux/qr_4t1_mux.sv
`default_nettype none

module qr_4t1_mux import tx_pkg::*; (
    input  wire logic    clk_tx,
    input  wire logic    arst_n,
    input  wire logic    nib_load,
    input  wire nibble_t nib,
    output logic         data      // Serial bit, nibble bit 3 first
);

    nibble_t sr;
    logic    primed;  // Set once the first nibble has been captured

    // Loads on nib_load, shifts one bit per cycle otherwise
    always_ff @(posedge clk_tx) begin
        if (nib_load) begin
            sr <= nib;
        end else begin
            sr <= {sr[NIB_W-2:0], 1'b0};  // Left shift, top bit goes out
        end
    end

    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            primed <= 1'b0;
        end else if (nib_load) begin
            primed <= 1'b1;
        end
    end

    // Known low until the first nibble arrives
    assign data = primed & sr[NIB_W-1];

endmodule

`default_nettype wire

// File: src/tx_output_driver.sv
`default_nettype none

module tx_output_driver import tx_pkg::*; (
    input  wire logic clk_tx,
    input  wire logic arst_n,
    input  wire logic en_drv,
    input  wire logic pol_inv,       // Swap the two legs of the pair
    input  wire logic word_load,
    input  wire logic word_is_data,  // Low when the slot carries IDLE_WORD
    input  wire logic din_p,
    input  wire logic din_n,
    output logic      sof,           // First bit of a data word
    output logic      dout_p,
    output logic      dout_n
);

    drv_state_e              state;
    logic [SOF_DELAY-2:0]    wl_pipe;   // word_load delayed, marks word starts
    logic [SOF_DELAY-2:0]    dat_pipe;  // Same, data words only
    logic                    drv_on_nxt;

    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            wl_pipe  <= '0;
            dat_pipe <= '0;
        end else begin
            wl_pipe  <= {wl_pipe[SOF_DELAY-3:0], word_load};
            dat_pipe <= {dat_pipe[SOF_DELAY-3:0], word_load & word_is_data};
        end
    end

    // en_drv takes effect only where a word starts on the pair
    // Also keeps the unfilled lanes after reset off the line
    assign drv_on_nxt = wl_pipe[SOF_DELAY-2] ? en_drv : (state == DRV_ON);

    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            state <= DRV_OFF;
        end else begin
            state <= drv_on_nxt ? DRV_ON : DRV_OFF;
        end
    end

    always_ff @(posedge clk_tx or negedge arst_n) begin
        if (!arst_n) begin
            dout_p <= 1'b0;  // Rest level
            dout_n <= 1'b1;
            sof    <= 1'b0;
        end else if (drv_on_nxt) begin
            dout_p <= pol_inv ? din_n : din_p;
            dout_n <= pol_inv ? din_p : din_n;
            sof    <= dat_pipe[SOF_DELAY-2];
        end else begin
            dout_p <= 1'b0;
            dout_n <= 1'b1;
            sof    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: src/tx_top.sv
`default_nettype none

module tx_top import tx_pkg::*; (
    input  wire logic  clk_tx,         // Bit-rate clock
    input  wire logic  arst_n,
    input  wire word_t din,
    input  wire logic  din_valid,
    input  wire logic  en_drv,
    input  wire logic  pol_inv,
    output wire logic  credit_return,  // One credit back per word sent
    output wire logic  sof,
    output wire logic  dout_p,
    output wire logic  dout_n
);

    // Timing strobes
    wire logic nib_load;
    wire logic word_load;

    // FIFO head
    word_t     head;
    wire logic head_valid;

    // Word handed to both lanes, idle pattern when starved
    word_t     lane_word;
    assign lane_word = head_valid ? head : IDLE_WORD;

    nibble_t   qr_data_p;  // 16 to 4 output, true lane
    nibble_t   qr_data_n;  // 16 to 4 output, complement lane
    wire logic mtb_p;      // Mux to driver, true
    wire logic mtb_n;      // Mux to driver, complement

    tx_word_fifo fifo_i (
        .clk_tx        (clk_tx),
        .arst_n        (arst_n),
        .din           (din),
        .din_valid     (din_valid),
        .pop           (word_load),   // Pops only if a word is waiting
        .head          (head),
        .head_valid    (head_valid),
        .credit_return (credit_return)
    );

    tx_phase_counter phase_i (
        .clk_tx    (clk_tx),
        .arst_n    (arst_n),
        .nib_load  (nib_load),
        .word_load (word_load)
    );

    // True lane
    hr_16t4_mux hr_mux_16t4_0 (
        .clk_tx    (clk_tx),
        .arst_n    (arst_n),
        .word_load (word_load),
        .nib_load  (nib_load),
        .din       (lane_word),
        .nib       (qr_data_p)
    );

    qr_4t1_mux qr_mux_4t1_0 (
        .clk_tx   (clk_tx),
        .arst_n   (arst_n),
        .nib_load (nib_load),
        .nib      (qr_data_p),
        .data     (mtb_p)
    );

    // Complement lane, separate chain so a fault breaks the pair
    hr_16t4_mux hr_mux_16t4_1 (
        .clk_tx    (clk_tx),
        .arst_n    (arst_n),
        .word_load (word_load),
        .nib_load  (nib_load),
        .din       (~lane_word),  // Inverted for the n leg
        .nib       (qr_data_n)
    );

    qr_4t1_mux qr_mux_4t1_1 (
        .clk_tx   (clk_tx),
        .arst_n   (arst_n),
        .nib_load (nib_load),
        .nib      (qr_data_n),
        .data     (mtb_n)
    );

    tx_output_driver drv_i (
        .clk_tx       (clk_tx),
        .arst_n       (arst_n),
        .en_drv       (en_drv),
        .pol_inv      (pol_inv),
        .word_load    (word_load),
        .word_is_data (head_valid),   // Sampled with word_load
        .din_p        (mtb_p),
        .din_n        (mtb_n),
        .sof          (sof),
        .dout_p       (dout_p),
        .dout_n       (dout_n)
    );

endmodule

`default_nettype wire

// File: bench/tb_tx_top.sv
module tb_tx_top import tx_pkg::*; ();

    localparam int NUM_WORDS = 20;
    localparam int SHOWN     = 14;  // Words sent while the driver is on
    localparam int SETTLE    = 40;  // Pop to last bit on the pair, with room
    // Per word at most 16 cycles of gap and 16 waiting for a credit
    localparam int TIMEOUT   = NUM_WORDS * WORD_W * 2 + 640;

    logic        clk_tx;
    logic        arst_n;
    word_t       din;
    logic        din_valid;
    logic        en_drv;
    logic        pol_inv;
    wire logic   credit_return;
    wire logic   sof;
    wire logic   dout_p;
    wire logic   dout_n;

    integer      seed = 83;
    int          credits;   // Upstream credit counter
    int          matched;   // Data words rebuilt and compared
    int          cycles;
    int          bit_cnt;   // Serial bits collected since sof
    word_t       rx_word;
    logic        prev_p;
    logic        idle_chk;  // FIFO starved, line must alternate
    logic        off_chk;   // Driver off, line at rest
    word_t       exp_q[$];  // Words expected on the pair, oldest first

    tx_top tx_top_i (
        .clk_tx        (clk_tx),
        .arst_n        (arst_n),
        .din           (din),
        .din_valid     (din_valid),
        .en_drv        (en_drv),
        .pol_inv       (pol_inv),
        .credit_return (credit_return),
        .sof           (sof),
        .dout_p        (dout_p),
        .dout_n        (dout_n)
    );

    initial begin
        clk_tx = 1'b0;
    end

    always #50 clk_tx = ~clk_tx;

    task automatic fail_run(input string what);
        $display("%s (cycle %0d)", what, cycles);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERROR: %s expected 0x%0h, got 0x%0h at cycle %0d",
                     name, expected, actual, cycles);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // One clock, outputs sampled at the falling edge, all registered in the DUT
    task automatic step_cycle();
        logic  bit_in;
        word_t exp_word;
        @(negedge clk_tx);
        cycles++;
        if (cycles > TIMEOUT) begin
            fail_run("Timeout, the run did not finish within the cycle limit");
        end
        check_value("dout_n", 32'(!dout_p), 32'(dout_n));  // Pair stays complementary
        if (credit_return === 1'b1) begin
            credits++;
            if (credits > FIFO_DEPTH) begin
                fail_run("More credits came back than words were sent");
            end
        end
        if (idle_chk) begin
            check_value("sof", 0, 32'(sof));
            check_value("dout_p", 32'(!prev_p), 32'(dout_p));  // AAAA toggles every bit
        end
        if (off_chk) begin
            check_value("sof", 0, 32'(sof));
            check_value("dout_p", 0, 32'(dout_p));
            check_value("dout_n", 1, 32'(dout_n));
        end
        // True data sits on dout_n when the legs are swapped
        bit_in = pol_inv ? dout_n : dout_p;
        if (sof === 1'b1) begin
            if (bit_cnt != 0) begin
                fail_run("sof came in the middle of a word");
            end
            rx_word = word_t'(bit_in);
            bit_cnt = 1;
        end else if (bit_cnt != 0) begin
            rx_word = {rx_word[WORD_W-2:0], bit_in};  // MSB arrives first
            bit_cnt++;
        end
        if (bit_cnt == WORD_W) begin
            if (exp_q.size() == 0) begin
                fail_run("A data word came out with no word queued");
            end else begin
                exp_word = exp_q.pop_front();
                check_value("rx_word", 32'(exp_word), 32'(rx_word));
                matched++;
                bit_cnt = 0;
            end
        end
        prev_p = dout_p;
    endtask

    task automatic send_word(input logic shown);
        int gap;
        gap = 0;
        if (($random(seed) & 3) == 0) begin
            gap = $random(seed) & 15;  // Pause, FIFO drains toward idle
        end
        repeat (gap) step_cycle();
        while (credits == 0) begin
            step_cycle();  // Wait for a slot to free up
        end
        din       = word_t'($random(seed));
        din_valid = 1'b1;
        credits--;
        if (shown) begin
            exp_q.push_back(din);
        end
        step_cycle();
        din_valid = 1'b0;
    endtask

    // All credits home, then the last word clears the pair
    task automatic drain_pipeline();
        while (credits != FIFO_DEPTH) begin
            step_cycle();
        end
        repeat (SETTLE) step_cycle();
    endtask

    task automatic idle_window();
        idle_chk = 1'b1;
        repeat (2 * WORD_W) step_cycle();
        idle_chk = 1'b0;
    endtask

    initial begin
        arst_n    = 1'b0;
        din       = '0;
        din_valid = 1'b0;
        en_drv    = 1'b1;
        pol_inv   = 1'b0;
        credits   = FIFO_DEPTH;
        matched   = 0;
        cycles    = 0;
        bit_cnt   = 0;
        rx_word   = '0;
        prev_p    = 1'b0;
        idle_chk  = 1'b0;
        off_chk   = 1'b0;

        repeat (2) @(negedge clk_tx);
        // Rest level in reset
        check_value("credit_return", 0, 32'(credit_return));
        check_value("sof", 0, 32'(sof));
        check_value("dout_p", 0, 32'(dout_p));
        check_value("dout_n", 1, 32'(dout_n));
        arst_n = 1'b1;

        repeat (8) send_word(1'b1);  // Normal legs
        drain_pipeline();
        idle_window();

        pol_inv = 1'b1;
        repeat (4) step_cycle();
        idle_window();
        repeat (6) send_word(1'b1);  // Swapped legs
        drain_pipeline();

        // Driver parks at the next word start, FIFO still drains
        pol_inv = 1'b0;
        en_drv  = 1'b0;
        repeat (SETTLE) step_cycle();
        off_chk = 1'b1;
        repeat (6) send_word(1'b0);
        drain_pipeline();
        off_chk = 1'b0;

        en_drv = 1'b1;
        repeat (SETTLE) step_cycle();
        idle_window();

        check_value("words_matched", SHOWN, matched);
        $display("TEST PASS");
        $finish;
    end

endmodule

// File: verilog.f
common/tx_pkg.sv
src/tx_word_fifo.sv
src/tx_phase_counter.sv
mux/hr_16t4_mux.sv
mux/qr_4t1_mux.sv
src/tx_output_driver.sv
src/tx_top.sv
bench/tb_tx_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_tx_top
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
PASS_MSG  := TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
